/* include/dbg_cfg.svh */
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// clocks per oversampling tick
// kept small so a frame stays short in simulation
`define DBG_BAUD_DIV 4

// target register file depth
`define DBG_N_REG 8

// instruction memory depth in words
`define DBG_N_IMEM 32

// data memory depth in words
`define DBG_N_DMEM 8

// all-ones opcode with zero fields stops the target
`define DBG_HALT_WORD 32'hFC00_0000

`endif

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run, then scan the log
mkdir -p build
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_dbg_top \
	-f tb.f --Mdir build -o sim_tb_dbg_top \
	|| { echo "verilator build failed"; exit 1; }
./build/sim_tb_dbg_top > build/sim.log 2>&1 || echo "simulation exited with an error"
cat build/sim.log
! grep -q "TEST FAILED" build/sim.log && grep -q "TEST PASSED" build/sim.log

/* src/baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module baud_gen (
	input  wire  clock_i,
	input  wire  reset_i,
	output logic o_tick
);
	localparam int DIV = `DBG_BAUD_DIV;
	// at least one counter bit, even for a divider of 1
	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt_q;

	// one tick per DIV clocks, 16 ticks make one bit
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			cnt_q  <= '0;
			o_tick <= 1'b0;
		end else if (cnt_q == CW'(DIV - 1)) begin
			cnt_q  <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt_q  <= cnt_q + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/dbg_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

interface dbg_if;
	localparam int IMEM_AW = $clog2(`DBG_N_IMEM);
	localparam int REG_AW  = $clog2(`DBG_N_REG);
	localparam int DMEM_AW = $clog2(`DBG_N_DMEM);

	// run control and program load
	logic                 en_pipeline;
	logic                 imem_we;
	logic [IMEM_AW-1:0]   imem_addr;
	dbg_pkg::word_t       imem_wdata;
	logic                 restart;
	// state readback
	logic [REG_AW-1:0]    reg_addr;
	logic [DMEM_AW-1:0]   mem_addr;
	logic                 halt;
	dbg_pkg::word_t       reg_data;
	dbg_pkg::word_t       mem_data;
	dbg_pkg::word_t       pc;

	modport debug (
		output en_pipeline, imem_we, imem_addr, imem_wdata, restart, reg_addr, mem_addr,
		input  halt, reg_data, mem_data, pc
	);

	modport target (
		input  en_pipeline, imem_we, imem_addr, imem_wdata, restart, reg_addr, mem_addr,
		output halt, reg_data, mem_data, pc
	);

endinterface

`default_nettype wire

/* src/dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

	// instruction, register and memory word
	typedef logic [31:0] word_t;

	// host command bytes, one bit each
	typedef enum logic [7:0] {
		CMD_LOAD    = 8'h01,
		CMD_STEP    = 8'h02,
		CMD_CONT    = 8'h04,
		CMD_RESTART = 8'h08
	} cmd_e;

	// debug unit states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RECEIVE,
		ST_WRITE,
		ST_STEP,
		ST_RUN,
		ST_DUMP,
		ST_RESTART
	} state_e;

	// dump order: registers, data memory, pc
	typedef enum logic [1:0] {
		PH_REGS,
		PH_MEM,
		PH_PC,
		PH_DONE
	} phase_e;

	// target opcodes in bits 31:26
	typedef enum logic [5:0] {
		OP_ADDI = 6'b001000,
		OP_SW   = 6'b101011,
		OP_HALT = 6'b111111
	} opcode_e;

endpackage

`default_nettype wire

/* src/dbg_target.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module dbg_target (
	input wire    clock_i,
	input wire    reset_i,
	dbg_if.target dbg
);
	localparam int IMEM_AW = $clog2(`DBG_N_IMEM);
	localparam int REG_AW  = $clog2(`DBG_N_REG);
	localparam int DMEM_AW = $clog2(`DBG_N_DMEM);

	dbg_pkg::word_t    imem [`DBG_N_IMEM];
	dbg_pkg::word_t    regs [`DBG_N_REG];
	dbg_pkg::word_t    dmem [`DBG_N_DMEM];
	dbg_pkg::word_t    pc_q;
	dbg_pkg::word_t    instr;
	dbg_pkg::word_t    imm;
	dbg_pkg::word_t    sum;
	logic [5:0]        opcode;
	logic [REG_AW-1:0] rs_idx;
	logic [REG_AW-1:0] rt_idx;

	// fetch and decode, pc is a word index
	assign instr  = imem[pc_q[IMEM_AW-1:0]];
	assign opcode = instr[31:26];
	// register fields trimmed to the register file size
	assign rs_idx = instr[21 +: REG_AW];
	assign rt_idx = instr[16 +: REG_AW];
	assign imm    = {{16{instr[15]}}, instr[15:0]};
	// addi result and sw byte address
	assign sum    = regs[rs_idx] + imm;

	// host writes the program while the core is stopped
	always_ff @(posedge clock_i) begin
		if (dbg.imem_we) begin
			imem[dbg.imem_addr] <= dbg.imem_wdata;
		end
	end

	// register file, r0 is never written
	always_ff @(posedge clock_i) begin
		if (reset_i || dbg.restart) begin
			for (int i = 0; i < `DBG_N_REG; i++) begin
				regs[i] <= '0;
			end
		end else if (dbg.en_pipeline && opcode == dbg_pkg::OP_ADDI && rt_idx != '0) begin
			regs[rt_idx] <= sum;
		end
	end

	// word address wraps over the data memory
	always_ff @(posedge clock_i) begin
		if (dbg.en_pipeline && opcode == dbg_pkg::OP_SW) begin
			dmem[sum[2 +: DMEM_AW]] <= regs[rt_idx];
		end
	end

	// pc sticks at the halt word
	always_ff @(posedge clock_i) begin
		if (reset_i || dbg.restart) begin
			pc_q <= '0;
		end else if (dbg.en_pipeline && !dbg.halt) begin
			pc_q <= pc_q + 1'b1;
		end
	end

	assign dbg.halt     = (instr == `DBG_HALT_WORD);
	// readback ports for the dump
	assign dbg.reg_data = regs[dbg.reg_addr];
	assign dbg.mem_data = dmem[dbg.mem_addr];
	assign dbg.pc       = pc_q;

endmodule

`default_nettype wire

/* src/dbg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_top (
	input  wire  clock_i,
	input  wire  reset_i,
	input  wire  i_rx,
	output logic o_tx
);
	// debug unit to target bundle
	dbg_if u_dbg_if ();

	// host side, serial in and out
	debug_unit u_debug_unit (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.i_rx    (i_rx),
		.o_tx    (o_tx),
		.dbg     (u_dbg_if.debug)
	);

	// the core being debugged
	dbg_target u_dbg_target (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.dbg     (u_dbg_if.target)
	);

endmodule

`default_nettype wire

/* src/debug_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module debug_unit (
	input  wire  clock_i,
	input  wire  reset_i,
	input  wire  i_rx,
	output logic o_tx,
	dbg_if.debug dbg
);
	localparam int IMEM_AW = $clog2(`DBG_N_IMEM);
	localparam int REG_AW  = $clog2(`DBG_N_REG);
	localparam int DMEM_AW = $clog2(`DBG_N_DMEM);

	logic               tick;
	logic               rx_done;
	uart_pkg::byte_t    rx_byte;
	logic               tx_start;
	uart_pkg::byte_t    tx_byte;
	logic               tx_done;

	dbg_pkg::state_e    state_q;
	dbg_pkg::phase_e    phase_q;
	logic [1:0]         byte_cnt_q;
	logic               first_q;
	logic               halt_seen_q;
	logic [IMEM_AW-1:0] imem_addr_q;
	logic [REG_AW-1:0]  reg_addr_q;
	logic [DMEM_AW-1:0] mem_addr_q;
	dbg_pkg::word_t     word_q;
	dbg_pkg::word_t     next_word;
	dbg_pkg::word_t     dump_word;
	logic               send_go;

	baud_gen u_baud_gen (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.o_tick  (tick)
	);

	uart_rx u_uart_rx (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.i_tick  (tick),
		.i_rx    (i_rx),
		.o_done  (rx_done),
		.o_byte  (rx_byte)
	);

	uart_tx u_uart_tx (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.i_tick  (tick),
		.i_start (tx_start),
		.i_byte  (tx_byte),
		.o_tx    (o_tx),
		.o_done  (tx_done)
	);

	// low byte first, so each new byte enters at the top
	assign next_word = {rx_byte, word_q[31:8]};
	// first byte of a dump needs no tx_done
	assign send_go = (state_q == dbg_pkg::ST_DUMP) && (first_q || tx_done);

	// word being dumped
	always_comb begin
		case (phase_q)
			dbg_pkg::PH_REGS: dump_word = dbg.reg_data;
			dbg_pkg::PH_MEM:  dump_word = dbg.mem_data;
			default:          dump_word = dbg.pc;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q     <= dbg_pkg::ST_IDLE;
			phase_q     <= dbg_pkg::PH_REGS;
			byte_cnt_q  <= '0;
			first_q     <= 1'b0;
			halt_seen_q <= 1'b0;
			imem_addr_q <= '0;
			reg_addr_q  <= '0;
			mem_addr_q  <= '0;
			tx_start    <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state_q)
				dbg_pkg::ST_IDLE: begin
					// unknown codes leave us idle
					if (rx_done) begin
						case (rx_byte)
							dbg_pkg::CMD_LOAD: begin
								state_q     <= dbg_pkg::ST_RECEIVE;
								imem_addr_q <= '0;
								byte_cnt_q  <= '0;
							end
							dbg_pkg::CMD_STEP:    state_q <= dbg_pkg::ST_STEP;
							dbg_pkg::CMD_CONT:    state_q <= dbg_pkg::ST_RUN;
							dbg_pkg::CMD_RESTART: state_q <= dbg_pkg::ST_RESTART;
							default:              state_q <= dbg_pkg::ST_IDLE;
						endcase
					end
				end
				dbg_pkg::ST_RECEIVE: begin
					if (rx_done) begin
						byte_cnt_q <= byte_cnt_q + 1'b1;
						// fourth byte completes the word
						if (byte_cnt_q == 2'd3) begin
							halt_seen_q <= (next_word == `DBG_HALT_WORD);
							state_q     <= dbg_pkg::ST_WRITE;
						end
					end
				end
				dbg_pkg::ST_WRITE: begin
					// imem_we is high for this one cycle
					imem_addr_q <= imem_addr_q + 1'b1;
					state_q     <= halt_seen_q ? dbg_pkg::ST_IDLE : dbg_pkg::ST_RECEIVE;
				end
				dbg_pkg::ST_STEP, dbg_pkg::ST_RUN: begin
					// step dumps after one cycle, run waits for halt
					if (state_q == dbg_pkg::ST_STEP || dbg.halt) begin
						state_q    <= dbg_pkg::ST_DUMP;
						phase_q    <= dbg_pkg::PH_REGS;
						first_q    <= 1'b1;
						byte_cnt_q <= '0;
						reg_addr_q <= '0;
						mem_addr_q <= '0;
					end
				end
				dbg_pkg::ST_DUMP: begin
					if (send_go) begin
						first_q <= 1'b0;
						if (phase_q == dbg_pkg::PH_DONE) begin
							// tx_done of the last pc byte
							state_q <= dbg_pkg::ST_IDLE;
						end else begin
							tx_start   <= 1'b1;
							byte_cnt_q <= byte_cnt_q + 1'b1;
							// word sent, move to the next one
							if (byte_cnt_q == 2'd3) begin
								case (phase_q)
									dbg_pkg::PH_REGS: begin
										if (reg_addr_q == REG_AW'(`DBG_N_REG - 1)) begin
											phase_q <= dbg_pkg::PH_MEM;
										end else begin
											reg_addr_q <= reg_addr_q + 1'b1;
										end
									end
									dbg_pkg::PH_MEM: begin
										if (mem_addr_q == DMEM_AW'(`DBG_N_DMEM - 1)) begin
											phase_q <= dbg_pkg::PH_PC;
										end else begin
											mem_addr_q <= mem_addr_q + 1'b1;
										end
									end
									default: phase_q <= dbg_pkg::PH_DONE;
								endcase
							end
						end
					end
				end
				default: state_q <= dbg_pkg::ST_IDLE;
			endcase
		end
	end

	// instruction assembly and outgoing byte
	always_ff @(posedge clock_i) begin
		if (state_q == dbg_pkg::ST_RECEIVE && rx_done) begin
			word_q <= next_word;
		end
		if (send_go) begin
			tx_byte <= dump_word[{byte_cnt_q, 3'b000} +: 8];
		end
	end

	// target runs only while not halted
	assign dbg.en_pipeline = (state_q == dbg_pkg::ST_STEP || state_q == dbg_pkg::ST_RUN) &&
		!dbg.halt;
	assign dbg.imem_we    = (state_q == dbg_pkg::ST_WRITE);
	assign dbg.imem_addr  = imem_addr_q;
	assign dbg.imem_wdata = word_q;
	assign dbg.restart    = (state_q == dbg_pkg::ST_RESTART);
	assign dbg.reg_addr   = reg_addr_q;
	assign dbg.mem_addr   = mem_addr_q;

endmodule

`default_nettype wire

/* src/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// one serial payload byte
	typedef logic [7:0] byte_t;

	// receiver sequencing
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// transmitter sequencing
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  wire              clock_i,
	input  wire              reset_i,
	input  wire              i_tick,
	input  wire              i_rx,
	output logic             o_done,
	output uart_pkg::byte_t  o_byte
);
	uart_pkg::rx_state_e state_q;
	logic [1:0]          sync_q;
	logic                rx_s;
	logic [3:0]          tick_cnt;
	logic [2:0]          bit_cnt;
	uart_pkg::byte_t     shift_q;

	// two flops against metastability on the serial line
	assign rx_s = sync_q[1];

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			sync_q   <= 2'b11;
			state_q  <= uart_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			o_done   <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], i_rx};
			o_done <= 1'b0;
			case (state_q)
				uart_pkg::RX_IDLE: begin
					// falling edge may be a start bit
					if (!rx_s) begin
						state_q  <= uart_pkg::RX_START;
						tick_cnt <= '0;
					end
				end
				uart_pkg::RX_START: begin
					// half a bit later, still low means a real start bit
					if (i_tick) begin
						if (tick_cnt == 4'd7) begin
							tick_cnt <= '0;
							bit_cnt  <= '0;
							state_q  <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				uart_pkg::RX_DATA: begin
					// sample in the middle of each data bit
					if (i_tick) begin
						if (tick_cnt == 4'd15) begin
							tick_cnt <= '0;
							if (bit_cnt == 3'd7) begin
								state_q <= uart_pkg::RX_STOP;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				default: begin
					// mid stop bit, byte is complete
					if (i_tick) begin
						if (tick_cnt == 4'd15) begin
							o_done  <= 1'b1;
							state_q <= uart_pkg::RX_IDLE;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge clock_i) begin
		if (state_q == uart_pkg::RX_DATA && i_tick && tick_cnt == 4'd15) begin
			shift_q <= {rx_s, shift_q[7:1]};
		end
	end

	assign o_byte = shift_q;

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  wire              clock_i,
	input  wire              reset_i,
	input  wire              i_tick,
	input  wire              i_start,
	input  wire uart_pkg::byte_t i_byte,
	output logic             o_tx,
	output logic             o_done
);
	uart_pkg::tx_state_e state_q;
	logic [3:0]          tick_cnt;
	logic [2:0]          bit_cnt;
	uart_pkg::byte_t     shift_q;
	logic                line_d;
	logic                line_q;

	// line level for the current bit
	always_comb begin
		case (state_q)
			uart_pkg::TX_START: line_d = 1'b0;
			uart_pkg::TX_DATA:  line_d = shift_q[0];
			default:            line_d = 1'b1;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q  <= uart_pkg::TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			o_done   <= 1'b0;
			line_q   <= 1'b1;
		end else begin
			o_done <= 1'b0;
			// registered so the serial line never glitches
			line_q <= line_d;
			case (state_q)
				uart_pkg::TX_IDLE: begin
					// a start while busy never reaches this branch
					if (i_start) begin
						state_q  <= uart_pkg::TX_START;
						tick_cnt <= '0;
					end
				end
				uart_pkg::TX_START: begin
					if (i_tick) begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == 4'd15) begin
							bit_cnt <= '0;
							state_q <= uart_pkg::TX_DATA;
						end
					end
				end
				uart_pkg::TX_DATA: begin
					if (i_tick) begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == 4'd15) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7) begin
								state_q <= uart_pkg::TX_STOP;
							end
						end
					end
				end
				default: begin
					// end of stop bit
					if (i_tick) begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == 4'd15) begin
							o_done  <= 1'b1;
							state_q <= uart_pkg::TX_IDLE;
						end
					end
				end
			endcase
		end
	end

	// latch on start, then shift out lsb first
	always_ff @(posedge clock_i) begin
		if (state_q == uart_pkg::TX_IDLE && i_start) begin
			shift_q <= i_byte;
		end else if (state_q == uart_pkg::TX_DATA && i_tick && tick_cnt == 4'd15) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

	assign o_tx = line_q;

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
src/uart_pkg.sv
src/dbg_pkg.sv
src/dbg_if.sv
src/baud_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/debug_unit.sv
src/dbg_target.sv
src/dbg_top.sv
tests/tb_dbg_top.sv

/* tests/tb_dbg_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module tb_dbg_top;
	localparam int BIT_CLKS   = 16 * `DBG_BAUD_DIV;
	localparam int START_WAIT = 60 * BIT_CLKS;
	localparam int QUIET_CLKS = 30 * BIT_CLKS;
	localparam int RUN_LIMIT  = 1000;
	localparam int N_ROWS     = 14;
	localparam int N_PROG     = 3;

	logic clock_i;
	logic reset_i;
	logic i_rx;
	wire  o_tx;

	// stimulus table, one entry per host command
	string      row_name [N_ROWS];
	logic [7:0] row_cmd  [N_ROWS];
	int         row_prog [N_ROWS];
	bit         row_dump [N_ROWS];

	// programs sent by load rows
	dbg_pkg::word_t prog_word [N_PROG][`DBG_N_IMEM];
	int             prog_len  [N_PROG];

	// reference ISA state
	dbg_pkg::word_t m_imem [`DBG_N_IMEM];
	dbg_pkg::word_t m_regs [`DBG_N_REG];
	dbg_pkg::word_t m_dmem [`DBG_N_DMEM];
	dbg_pkg::word_t m_pc;

	// state dump as seen on o_tx
	dbg_pkg::word_t got_regs [`DBG_N_REG];
	dbg_pkg::word_t got_dmem [`DBG_N_DMEM];
	dbg_pkg::word_t got_pc;

	integer seed;
	int     error_count;
	int     timeout_count;

	dbg_top u_dbg_top (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.i_rx    (i_rx),
		.o_tx    (o_tx)
	);

	always #5 clock_i = ~clock_i;

	// inputs change 1 ns after the rising edge
	task automatic hold_clocks(input int n);
		repeat (n) @(posedge clock_i);
		#1;
	endtask

	task automatic check_value(input string name, input dbg_pkg::word_t exp,
		input dbg_pkg::word_t act);
		if (act !== exp) begin
			$display("error %s: expected %h actual %h", name, exp, act);
			error_count++;
		end
	endtask

	function automatic dbg_pkg::word_t encode_addi(input logic [2:0] rs, input logic [2:0] rt,
		input logic [15:0] imm);
		return {dbg_pkg::OP_ADDI, 2'b00, rs, 2'b00, rt, imm};
	endfunction

	function automatic dbg_pkg::word_t encode_sw(input logic [2:0] rs, input logic [2:0] rt,
		input logic [15:0] imm);
		return {dbg_pkg::OP_SW, 2'b00, rs, 2'b00, rt, imm};
	endfunction

	// host side 8N1 frame, lsb first
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			i_rx = frame[i];
			hold_clocks(BIT_CLKS);
		end
	endtask

	task automatic send_program(input int p);
		int i;
		int j;
		for (i = 0; i < prog_len[p]; i++) begin
			for (j = 0; j < 4; j++) begin
				send_byte(prog_word[p][i][8*j +: 8]);
			end
		end
	endtask

	task automatic receive_byte(output logic [7:0] b, output bit ok);
		int wait_cnt;
		int i;
		ok = 1'b0;
		b = '0;
		wait_cnt = 0;
		while (o_tx !== 1'b0 && wait_cnt < START_WAIT) begin
			hold_clocks(1);
			wait_cnt++;
		end
		if (o_tx !== 1'b0) begin
			$display("timeout: no start bit on o_tx within %0d clocks", START_WAIT);
			timeout_count++;
		end else begin
			// move to the middle of the start bit
			hold_clocks(BIT_CLKS / 2);
			for (i = 0; i < 8; i++) begin
				hold_clocks(BIT_CLKS);
				b[i] = o_tx;
			end
			hold_clocks(BIT_CLKS);
			if (o_tx !== 1'b1) begin
				$display("stop bit on o_tx was not high");
				error_count++;
			end
			ok = 1'b1;
		end
	endtask

	// low byte first
	task automatic receive_word(output dbg_pkg::word_t w, output bit ok);
		logic [7:0] b;
		int j;
		w = '0;
		ok = 1'b1;
		for (j = 0; j < 4 && ok; j++) begin
			receive_byte(b, ok);
			w[8*j +: 8] = b;
		end
	endtask

	// registers, then data memory, then pc
	task automatic receive_dump(output bit ok);
		int i;
		ok = 1'b1;
		for (i = 0; i < `DBG_N_REG && ok; i++) begin
			receive_word(got_regs[i], ok);
		end
		for (i = 0; i < `DBG_N_DMEM && ok; i++) begin
			receive_word(got_dmem[i], ok);
		end
		if (ok) begin
			receive_word(got_pc, ok);
		end
	endtask

	// no start bit may show up in the window
	task automatic expect_quiet(input string name);
		int n;
		for (n = 0; n < QUIET_CLKS; n++) begin
			if (o_tx === 1'b0) begin
				$display("%s: unexpected start bit on o_tx when no reply was due", name);
				error_count++;
				break;
			end
			hold_clocks(1);
		end
	endtask

	task automatic compare_dump(input string name);
		int i;
		for (i = 0; i < `DBG_N_REG; i++) begin
			check_value($sformatf("%s reg%0d", name, i), m_regs[i], got_regs[i]);
		end
		for (i = 0; i < `DBG_N_DMEM; i++) begin
			check_value($sformatf("%s mem%0d", name, i), m_dmem[i], got_dmem[i]);
		end
		check_value($sformatf("%s pc", name), m_pc, got_pc);
	endtask

	task automatic clear_core_state();
		int i;
		m_pc = '0;
		for (i = 0; i < `DBG_N_REG; i++) begin
			m_regs[i] = '0;
		end
	endtask

	// one instruction, nothing happens at the halt word
	task automatic execute_one();
		dbg_pkg::word_t w;
		dbg_pkg::word_t imm;
		dbg_pkg::word_t addr;
		int rs;
		int rt;
		w = m_imem[int'(m_pc % `DBG_N_IMEM)];
		rs = int'(w[25:21]);
		rt = int'(w[20:16]);
		imm = {{16{w[15]}}, w[15:0]};
		if (w != `DBG_HALT_WORD) begin
			if (w[31:26] == dbg_pkg::OP_ADDI) begin
				// r0 is hardwired
				if (rt != 0) begin
					m_regs[rt] = m_regs[rs] + imm;
				end
			end else if (w[31:26] == dbg_pkg::OP_SW) begin
				addr = (m_regs[rs] + imm) >> 2;
				m_dmem[int'(addr % `DBG_N_DMEM)] = m_regs[rt];
			end
			m_pc = m_pc + 1;
		end
	endtask

	task automatic predict_command(input logic [7:0] cmd, input int p);
		int i;
		int n;
		case (cmd)
			dbg_pkg::CMD_LOAD: begin
				for (i = 0; i < prog_len[p]; i++) begin
					m_imem[i] = prog_word[p][i];
				end
			end
			dbg_pkg::CMD_STEP: execute_one();
			dbg_pkg::CMD_CONT: begin
				n = 0;
				while (m_imem[int'(m_pc % `DBG_N_IMEM)] != `DBG_HALT_WORD && n < RUN_LIMIT) begin
					execute_one();
					n++;
				end
			end
			dbg_pkg::CMD_RESTART: clear_core_state();
			default: ;
		endcase
	endtask

	task automatic build_programs();
		logic [31:0] r;
		logic [2:0]  rt;
		int          i;
		int          k;
		// program 0: addi mix, a store to every data word, halt
		k = 0;
		for (i = 0; i < 6; i++) begin
			r = $random(seed);
			rt = r[5:3];
			// first instruction must leave a visible trace
			if (i == 0 && rt == 3'd0) begin
				rt = 3'd1;
			end
			prog_word[0][k] = encode_addi(r[2:0], rt, r[31:16]);
			k++;
		end
		for (i = 0; i < `DBG_N_DMEM; i++) begin
			r = $random(seed);
			prog_word[0][k] = encode_sw(3'd0, r[2:0], {11'd0, 3'(i), 2'b00});
			k++;
		end
		for (i = 0; i < 2; i++) begin
			r = $random(seed);
			prog_word[0][k] = encode_addi(r[2:0], r[5:3], r[31:16]);
			k++;
		end
		// store with a random address, wraps over data memory
		r = $random(seed);
		prog_word[0][k] = encode_sw(r[2:0], r[5:3], r[31:16]);
		prog_word[0][k + 1] = `DBG_HALT_WORD;
		prog_len[0] = k + 2;
		// program 1: halt straight away
		prog_word[1][0] = `DBG_HALT_WORD;
		prog_len[1] = 1;
		// program 2: writes aimed at r0, then one real write
		r = $random(seed);
		prog_word[2][0] = encode_addi(r[2:0], 3'd0, r[31:16]);
		prog_word[2][1] = encode_addi(3'd0, 3'd0, r[15:0]);
		prog_word[2][2] = encode_addi(3'd0, 3'd5, r[23:8]);
		prog_word[2][3] = encode_addi(3'd5, 3'd0, r[31:16]);
		prog_word[2][4] = `DBG_HALT_WORD;
		prog_len[2] = 5;
	endtask

	task automatic add_row(input int idx, input string name, input logic [7:0] cmd,
		input int p, input bit dump);
		row_name[idx] = name;
		row_cmd[idx]  = cmd;
		row_prog[idx] = p;
		row_dump[idx] = dump;
	endtask

	task automatic fill_table();
		add_row(0, "load_a", dbg_pkg::CMD_LOAD, 0, 1'b0);
		add_row(1, "continue_a", dbg_pkg::CMD_CONT, -1, 1'b1);
		add_row(2, "restart_a", dbg_pkg::CMD_RESTART, -1, 1'b0);
		add_row(3, "step_first", dbg_pkg::CMD_STEP, -1, 1'b1);
		add_row(4, "continue_to_halt", dbg_pkg::CMD_CONT, -1, 1'b1);
		add_row(5, "step_at_halt", dbg_pkg::CMD_STEP, -1, 1'b1);
		add_row(6, "load_halt_first", dbg_pkg::CMD_LOAD, 1, 1'b0);
		add_row(7, "restart_b", dbg_pkg::CMD_RESTART, -1, 1'b0);
		add_row(8, "step_halt_first", dbg_pkg::CMD_STEP, -1, 1'b1);
		// 0x55 is no command
		add_row(9, "unknown_cmd", 8'h55, -1, 1'b0);
		add_row(10, "step_after_unknown", dbg_pkg::CMD_STEP, -1, 1'b1);
		add_row(11, "load_r0", dbg_pkg::CMD_LOAD, 2, 1'b0);
		add_row(12, "restart_c", dbg_pkg::CMD_RESTART, -1, 1'b0);
		add_row(13, "continue_r0", dbg_pkg::CMD_CONT, -1, 1'b1);
	endtask

	initial begin
		int  r;
		int  i;
		bit  ok;
		bit  abort;
		clock_i = 1'b0;
		reset_i = 1'b1;
		i_rx = 1'b1;
		seed = 32'h6ecb_2491;
		error_count = 0;
		timeout_count = 0;
		abort = 1'b0;
		fill_table();
		build_programs();
		for (i = 0; i < `DBG_N_IMEM; i++) begin
			m_imem[i] = '0;
		end
		for (i = 0; i < `DBG_N_DMEM; i++) begin
			m_dmem[i] = '0;
		end
		clear_core_state();
		repeat (2) @(posedge clock_i);
		#1;
		reset_i = 1'b0;
		hold_clocks(4);
		for (r = 0; r < N_ROWS && !abort; r++) begin
			predict_command(row_cmd[r], row_prog[r]);
			if (row_dump[r]) begin
				// dump can start before the command's stop bit ends
				fork
					send_byte(row_cmd[r]);
					receive_dump(ok);
				join
				if (ok) begin
					compare_dump(row_name[r]);
				end else begin
					abort = 1'b1;
				end
			end else begin
				send_byte(row_cmd[r]);
				if (row_cmd[r] == dbg_pkg::CMD_LOAD) begin
					send_program(row_prog[r]);
				end
				expect_quiet(row_name[r]);
			end
		end
		$display("errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
